// ==== Makefile ====
# Verilator build and run of the lookup stage testbench

SIM    = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_stk_lk
FLIST  = compile.f
BUILD  = obj_dir
BIN    = $(BUILD)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== compile.f ====
hw/stk_pkg.sv
hw/stk_ptr_table.sv
hw/stk_lk_ctrl.sv
hw/stk_sram_cmd.sv
hw/stk_lk_top.sv
sim/stk_lk_checker.sv
sim/tb_stk_lk.sv

// ==== hw/stk_lk_ctrl.sv ====
`timescale 1ns/10ps
// Lookup control: opcode decode, per-engine empty flags,
// command status and the head/tail microcode bits
module stk_lk_ctrl #(
  parameter int ENGS_N = 4
) (
  input  logic              clk
, input  logic              i_reset

// Lookup command
, input  logic              i_lk_vld
, input  stk_pkg::engid_t   i_lk_engid
, input  stk_pkg::opcode_t  i_lk_opcode
, input  logic              i_lk_isfull

// Pointer table read data for this engine
, input  stk_pkg::ptr_t     i_head_ptr
, input  stk_pkg::ptr_t     i_tail_ptr

// Decoded command strobes
, output logic              o_cmd_push
, output logic              o_cmd_pop
, output logic              o_cmd_inv

// Microcode fields
, output stk_pkg::status_t  o_status
, output logic              o_head_upt
, output logic              o_tail_vld
);

  import stk_pkg::*;

  logic [ENGS_N-1:0] empty_r;
  logic [ENGS_N-1:0] empty_nxt;
  logic [ENGS_N-1:0] engid_dec;
  logic              is_empty;
  logic              empty_set;
  logic              empty_clr;
  logic              err_empty;
  logic              err_full;

  // Opcode decode, all three strobes from one block
  always_comb begin
    o_cmd_push = 1'b0;
    o_cmd_pop  = 1'b0;
    o_cmd_inv  = 1'b0;
    if (i_lk_vld) begin
      case (i_lk_opcode)
        OPCODE_PUSH: o_cmd_push = 1'b1;
        OPCODE_POP:  o_cmd_pop  = 1'b1;
        OPCODE_INV:  o_cmd_inv  = 1'b1;
        default:     ;
      endcase
    end
  end

  // One-hot engine id and its empty flag
  always_comb begin
    engid_dec = '0;
    is_empty  = 1'b0;
    for (int i = 0; i < ENGS_N; i++) begin
      if (i_lk_engid == engid_t'(i)) begin
        engid_dec[i] = 1'b1;
        is_empty     = empty_r[i];
      end
    end
  end

  // Pop or inv from an empty stack
  assign err_empty = (o_cmd_pop | o_cmd_inv) & is_empty;
  // Push with no free slot left
  assign err_full = o_cmd_push & i_lk_isfull;

  always_comb begin
    if (err_empty) begin
      o_status = STATUS_ERREMPTY;
    end else if (err_full) begin
      o_status = STATUS_ERRFULL;
    end else begin
      o_status = STATUS_OKAY;
    end
  end

  // First push leaves the engine non-empty
  assign empty_clr = o_cmd_push & is_empty;
  // Pop of the last entry, head meets tail (inv never sets)
  assign empty_set = o_cmd_pop & ~is_empty & (i_head_ptr == i_tail_ptr);

  assign empty_nxt = ~({ENGS_N{empty_clr}} & engid_dec)
                   & (empty_r | ({ENGS_N{empty_set}} & engid_dec));

  // All engines start empty
  always_ff @(posedge clk) begin
    if (i_reset) begin
      empty_r <= '1;
    end else begin
      empty_r <= empty_nxt;
    end
  end

  // Head holds a link only once the stack has an entry
  assign o_head_upt = ~is_empty;
  // Push to empty sets tail together with head
  assign o_tail_vld = o_cmd_push & is_empty;

  // At most one command per cycle
  a_one_cmd : assert property (@(posedge clk) disable iff (i_reset)
    $onehot0({o_cmd_push, o_cmd_pop, o_cmd_inv}));

endmodule : stk_lk_ctrl

// ==== hw/stk_lk_top.sv ====
`timescale 1ns/10ps
// Stack engine lookup stage: pointer tables, control and
// SRAM command generation, microcode out to write-back
module stk_lk_top #(
  parameter int ENGS_N = 4
, parameter int DAT_W = 128
) (
  input  logic                clk
, input  logic                i_reset

// Lookup command
, input  logic                i_lk_vld
, input  stk_pkg::engid_t     i_lk_engid
, input  stk_pkg::opcode_t    i_lk_opcode
, input  logic                i_lk_isfull
, input  logic [DAT_W-1:0]    i_lk_dat
// Freshly allocated slot
, input  stk_pkg::ptr_t       i_lk_ptr

// Write-back update
, input  logic                i_wrbk_vld
, input  stk_pkg::engid_t     i_wrbk_engid
, input  logic                i_wrbk_head_vld
, input  stk_pkg::ptr_t       i_wrbk_head_ptr
, input  logic                i_wrbk_tail_vld
, input  stk_pkg::ptr_t       i_wrbk_tail_ptr

// PREV SRAM
, output stk_pkg::bank_sel_t  o_prev_ce
, output stk_pkg::bank_sel_t  o_prev_oe
, output stk_pkg::line_id_t   o_prev_addr
, output stk_pkg::ptr_t       o_prev_din

// DATA SRAM
, output stk_pkg::bank_sel_t  o_dat_ce
, output stk_pkg::bank_sel_t  o_dat_oe
, output stk_pkg::line_id_t   o_dat_addr
, output logic [DAT_W-1:0]    o_dat_din

// Microcode to write-back
, output logic                o_uc_vld
, output stk_pkg::engid_t     o_uc_engid
, output stk_pkg::bank_sel_t  o_uc_bank_sel
, output stk_pkg::opcode_t    o_uc_opcode
, output stk_pkg::status_t    o_uc_status
, output logic                o_uc_head_vld
, output logic                o_uc_head_upt
, output stk_pkg::ptr_t       o_uc_head_ptr
, output logic                o_uc_tail_vld
, output stk_pkg::ptr_t       o_uc_tail_ptr
);

  import stk_pkg::*;

  ptr_t head_ptr;
  ptr_t tail_ptr;
  logic cmd_push;
  logic cmd_pop;
  logic cmd_inv;

  // Head and tail of the addressed engine
  stk_ptr_table #(.ENGS_N(ENGS_N)) u_ptr_table (
    .clk              (clk)
  , .i_reset          (i_reset)
  , .i_rd_engid       (i_lk_engid)
  , .o_head_ptr       (head_ptr)
  , .o_tail_ptr       (tail_ptr)
  , .i_wrbk_vld       (i_wrbk_vld)
  , .i_wrbk_engid     (i_wrbk_engid)
  , .i_wrbk_head_vld  (i_wrbk_head_vld)
  , .i_wrbk_head_ptr  (i_wrbk_head_ptr)
  , .i_wrbk_tail_vld  (i_wrbk_tail_vld)
  , .i_wrbk_tail_ptr  (i_wrbk_tail_ptr)
  );

  // Decode, empty tracking, status
  stk_lk_ctrl #(.ENGS_N(ENGS_N)) u_lk_ctrl (
    .clk          (clk)
  , .i_reset      (i_reset)
  , .i_lk_vld     (i_lk_vld)
  , .i_lk_engid   (i_lk_engid)
  , .i_lk_opcode  (i_lk_opcode)
  , .i_lk_isfull  (i_lk_isfull)
  , .i_head_ptr   (head_ptr)
  , .i_tail_ptr   (tail_ptr)
  , .o_cmd_push   (cmd_push)
  , .o_cmd_pop    (cmd_pop)
  , .o_cmd_inv    (cmd_inv)
  , .o_status     (o_uc_status)
  , .o_head_upt   (o_uc_head_upt)
  , .o_tail_vld   (o_uc_tail_vld)
  );

  // SRAM strobes, issued even on an error status
  stk_sram_cmd u_sram_cmd (
    .i_cmd_push   (cmd_push)
  , .i_cmd_pop    (cmd_pop)
  , .i_cmd_inv    (cmd_inv)
  , .i_alloc_ptr  (i_lk_ptr)
  , .i_head_ptr   (head_ptr)
  , .o_prev_ce    (o_prev_ce)
  , .o_prev_oe    (o_prev_oe)
  , .o_prev_addr  (o_prev_addr)
  , .o_prev_din   (o_prev_din)
  , .o_dat_ce     (o_dat_ce)
  , .o_dat_oe     (o_dat_oe)
  , .o_dat_addr   (o_dat_addr)
  , .o_bank_sel   (o_uc_bank_sel)
  );

  // Payload goes straight to the DATA SRAM
  assign o_dat_din = i_lk_dat;

  // Command fields pass through to write-back
  assign o_uc_vld    = i_lk_vld;
  assign o_uc_engid  = i_lk_engid;
  assign o_uc_opcode = i_lk_opcode;

  // Every decoded command moves the head
  assign o_uc_head_vld = cmd_push | cmd_pop | cmd_inv;
  // New slot becomes head, and tail too when it was empty
  assign o_uc_head_ptr = i_lk_ptr;
  assign o_uc_tail_ptr = i_lk_ptr;

endmodule : stk_lk_top

// ==== hw/stk_pkg.sv ====
// Widths, pointer and bank types of the stack lookup stage
// Opcode and status encodings carried in the microcode
package stk_pkg;

  // Engine contexts supported by the id field
  localparam int ENGS_MAX = 8;
  localparam int ENGID_W = $clog2(ENGS_MAX);

  // Banked SRAM geometry
  localparam int BANKS_N = 4;
  localparam int BANK_ID_W = $clog2(BANKS_N);
  localparam int LINE_ID_W = 6;

  // Pointer is bank id over line id
  localparam int PTR_W = BANK_ID_W + LINE_ID_W;

  // Command and result field widths
  localparam int OPCODE_W = 2;
  localparam int STATUS_W = 2;

  // Engine context id
  typedef logic [ENGID_W-1:0] engid_t;

  // Encoded bank number
  typedef logic [BANK_ID_W-1:0] bank_id_t;

  // One bit per bank
  typedef logic [BANKS_N-1:0] bank_sel_t;

  // Line within a bank
  typedef logic [LINE_ID_W-1:0] line_id_t;

  // List pointer, bank id in the upper bits
  typedef logic [PTR_W-1:0] ptr_t;

  // Lookup commands
  typedef logic [OPCODE_W-1:0] opcode_t;

  localparam opcode_t OPCODE_PUSH = 2'b00;
  localparam opcode_t OPCODE_POP = 2'b01;
  // Pop without the data read
  localparam opcode_t OPCODE_INV = 2'b10;

  // Command result
  typedef logic [STATUS_W-1:0] status_t;

  localparam status_t STATUS_OKAY = 2'b00;
  localparam status_t STATUS_ERREMPTY = 2'b01;
  localparam status_t STATUS_ERRFULL = 2'b10;

endpackage : stk_pkg

// ==== hw/stk_ptr_table.sv ====
`timescale 1ns/10ps
// Per-engine head and tail pointer tables
// Asynchronous read port, one write port from write-back
module stk_ptr_table #(
  parameter int ENGS_N = 4
) (
  input  logic              clk
, input  logic              i_reset

// Lookup read port
, input  stk_pkg::engid_t   i_rd_engid
, output stk_pkg::ptr_t     o_head_ptr
, output stk_pkg::ptr_t     o_tail_ptr

// Write-back update
, input  logic              i_wrbk_vld
, input  stk_pkg::engid_t   i_wrbk_engid
, input  logic              i_wrbk_head_vld
, input  stk_pkg::ptr_t     i_wrbk_head_ptr
, input  logic              i_wrbk_tail_vld
, input  stk_pkg::ptr_t     i_wrbk_tail_ptr
);

  import stk_pkg::*;

  ptr_t head_r [ENGS_N];
  ptr_t tail_r [ENGS_N];

  // Read mux, unmapped ids read as zero
  always_comb begin
    o_head_ptr = '0;
    o_tail_ptr = '0;
    for (int i = 0; i < ENGS_N; i++) begin
      if (i_rd_engid == engid_t'(i)) begin
        o_head_ptr = head_r[i];
        o_tail_ptr = tail_r[i];
      end
    end
  end

  // Write port, new value readable next cycle
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < ENGS_N; i++) begin
        head_r[i] <= '0;
        tail_r[i] <= '0;
      end
    end else if (i_wrbk_vld) begin
      for (int i = 0; i < ENGS_N; i++) begin
        if (i_wrbk_engid == engid_t'(i)) begin
          // Head and tail enables are independent
          if (i_wrbk_head_vld) begin
            head_r[i] <= i_wrbk_head_ptr;
          end
          if (i_wrbk_tail_vld) begin
            tail_r[i] <= i_wrbk_tail_ptr;
          end
        end
      end
    end
  end

  // Write-back stage only ever names a configured engine
  a_wrbk_engid : assert property (@(posedge clk) disable iff (i_reset)
    i_wrbk_vld |-> (int'(i_wrbk_engid) < ENGS_N));

endmodule : stk_ptr_table

// ==== hw/stk_sram_cmd.sv ====
`timescale 1ns/10ps
// Bank decode and PREV/DATA SRAM strobe, address and
// write data generation for one lookup command
module stk_sram_cmd (
// Command strobes
  input  logic                i_cmd_push
, input  logic                i_cmd_pop
, input  logic                i_cmd_inv

// Allocated slot and current head
, input  stk_pkg::ptr_t       i_alloc_ptr
, input  stk_pkg::ptr_t       i_head_ptr

// PREV SRAM
, output stk_pkg::bank_sel_t  o_prev_ce
, output stk_pkg::bank_sel_t  o_prev_oe
, output stk_pkg::line_id_t   o_prev_addr
, output stk_pkg::ptr_t       o_prev_din

// DATA SRAM
, output stk_pkg::bank_sel_t  o_dat_ce
, output stk_pkg::bank_sel_t  o_dat_oe
, output stk_pkg::line_id_t   o_dat_addr

// Bank touched, for write-back
, output stk_pkg::bank_sel_t  o_bank_sel
);

  import stk_pkg::*;

  bank_sel_t alloc_sel;
  bank_sel_t head_sel;
  line_id_t  alloc_line;
  line_id_t  head_line;
  logic      rd_head;

  // Bank id field to one-hot select
  function automatic bank_sel_t bank_dec(input ptr_t ptr);
    bank_id_t bank;
    bank = ptr[PTR_W-1 -: BANK_ID_W];
    return bank_sel_t'(1) << bank;
  endfunction

  assign alloc_sel  = bank_dec(i_alloc_ptr);
  assign head_sel   = bank_dec(i_head_ptr);
  assign alloc_line = i_alloc_ptr[LINE_ID_W-1:0];
  assign head_line  = i_head_ptr[LINE_ID_W-1:0];

  // Pop and inv both walk to the previous entry
  assign rd_head = i_cmd_pop | i_cmd_inv;

  // PREV: push writes the new slot, pop/inv read the head
  assign o_prev_ce = ({BANKS_N{i_cmd_push}} & alloc_sel)
                   | ({BANKS_N{rd_head}} & head_sel);
  assign o_prev_oe = {BANKS_N{rd_head}} & head_sel;
  assign o_prev_addr = i_cmd_push ? alloc_line : head_line;
  // Only consumed on a push write
  assign o_prev_din = i_alloc_ptr;

  // DATA: inv leaves the payload untouched
  assign o_dat_ce = ({BANKS_N{i_cmd_push}} & alloc_sel)
                  | ({BANKS_N{i_cmd_pop}} & head_sel);
  assign o_dat_oe = {BANKS_N{i_cmd_pop}} & head_sel;
  assign o_dat_addr = i_cmd_push ? alloc_line
                    : i_cmd_pop  ? head_line
                    : '0;

  assign o_bank_sel = i_cmd_push ? alloc_sel : head_sel;

  // One bank per SRAM per command, relies on exclusive strobes upstream
  always_comb begin
    a_prev_ce : assert ($onehot0(o_prev_ce));
    a_dat_ce : assert ($onehot0(o_dat_ce));
  end

endmodule : stk_sram_cmd

// ==== sim/stk_lk_checker.sv ====
`timescale 1ns/10ps
// Lookup stage checker: per-engine head, tail, empty and link model,
// reference function for the expected outputs, per-command compare
module stk_lk_checker #(
  parameter int ENGS_N = 4
, parameter int DAT_W = 128
) (
  input  logic                clk
, input  logic                i_reset
// Command as driven to the DUT
, input  logic                i_lk_vld
, input  stk_pkg::engid_t     i_lk_engid
, input  stk_pkg::opcode_t    i_lk_opcode
, input  logic                i_lk_isfull
, input  stk_pkg::ptr_t       i_lk_ptr
, input  logic [DAT_W-1:0]    i_lk_dat
// DUT response
, input  logic                i_uc_vld
, input  logic [65:0]         i_act
, input  logic [DAT_W-1:0]    i_dat_din
);

  import stk_pkg::*;

  ptr_t        head_m [ENGS_N];
  ptr_t        tail_m [ENGS_N];
  logic        empty_m [ENGS_N];
  ptr_t        link_m [256];
  logic [65:0] exp_v;
  status_t     exp_st;
  ptr_t        h;
  logic        e;
  int          err_cnt = 0;
  int          cmd_cnt = 0;

  // Expected SRAM strobes and microcode, same field order as i_act
  function automatic logic [65:0] ref_out(input opcode_t op, input logic full,
                                          input ptr_t p, input engid_t eng,
                                          input ptr_t hd, input logic emp);
    bank_sel_t as;
    bank_sel_t hs;
    bank_sel_t pce;
    bank_sel_t poe;
    bank_sel_t dce;
    bank_sel_t doe;
    bank_sel_t bs;
    line_id_t  paddr;
    line_id_t  daddr;
    status_t   st;
    as = 4'b0001 << p[7:6];
    hs = 4'b0001 << hd[7:6];
    if (op == OPCODE_PUSH) begin
      pce   = as;
      poe   = '0;
      paddr = p[5:0];
      dce   = as;
      doe   = '0;
      daddr = p[5:0];
      bs    = as;
    end else if (op == OPCODE_POP) begin
      pce   = hs;
      poe   = hs;
      paddr = hd[5:0];
      dce   = hs;
      doe   = hs;
      daddr = hd[5:0];
      bs    = hs;
    end else begin
      // INV reads PREV only
      pce   = hs;
      poe   = hs;
      paddr = hd[5:0];
      dce   = '0;
      doe   = '0;
      daddr = '0;
      bs    = hs;
    end
    if (op != OPCODE_PUSH && emp) st = STATUS_ERREMPTY;
    else if (op == OPCODE_PUSH && full) st = STATUS_ERRFULL;
    else st = STATUS_OKAY;
    return {pce, poe, paddr, p, dce, doe, daddr, bs, st, 1'b1, ~emp, p,
            (op == OPCODE_PUSH) & emp, p, eng, op};
  endfunction

  // Same fill as the PREV SRAM model
  initial begin
    for (int a = 0; a < 256; a++) link_m[a] = ptr_t'(a) ^ 8'h5a;
  end

  // Outputs settled half a cycle after the drive edge
  always @(negedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < ENGS_N; i++) begin
        head_m[i]  = '0;
        tail_m[i]  = '0;
        empty_m[i] = 1'b1;
      end
    end else begin
      // Microcode valid follows the command valid
      if (i_uc_vld !== i_lk_vld) begin
        err_cnt++;
        $display("[ERROR] %0t ns: o_uc_vld %b with command valid %b",
                 $time, i_uc_vld, i_lk_vld);
      end
      if (!i_lk_vld) begin
        // Idle cycle, no SRAM enable and no pointer update
        if ({i_act[65:58], i_act[43:36], i_act[23], i_act[13]} !== '0) begin
          err_cnt++;
          $display("[ERROR] %0t ns: strobes active with no command, got %h",
                   $time, i_act);
        end
      end else begin
        h = head_m[i_lk_engid];
        e = empty_m[i_lk_engid];
        exp_v = ref_out(i_lk_opcode, i_lk_isfull, i_lk_ptr, i_lk_engid, h, e);
        exp_st = exp_v[25:24];
        cmd_cnt++;
        if (exp_v !== i_act || i_dat_din !== i_lk_dat) begin
          err_cnt++;
          $display("[ERROR] %0t ns: engine %0d opcode %0d expected %h got %h",
                   $time, i_lk_engid, i_lk_opcode, exp_v, i_act);
        end
        // Model update, strobes write PREV even on error
        if (i_lk_opcode == OPCODE_PUSH) begin
          link_m[i_lk_ptr] = i_lk_ptr;
          if (exp_st == STATUS_OKAY) begin
            if (!e) link_m[i_lk_ptr] = h;
            head_m[i_lk_engid] = i_lk_ptr;
            if (e) tail_m[i_lk_engid] = i_lk_ptr;
          end
          if (e) empty_m[i_lk_engid] = 1'b0;
        end else if (exp_st == STATUS_OKAY) begin
          head_m[i_lk_engid] = link_m[h];
          // INV never empties
          if (i_lk_opcode == OPCODE_POP && h == tail_m[i_lk_engid]) begin
            empty_m[i_lk_engid] = 1'b1;
          end
        end
      end
    end
  end

endmodule : stk_lk_checker

// ==== sim/tb_stk_lk.sv ====
`timescale 1ns/10ps
// Lookup stage testbench: clock, reset, allocator, PREV SRAM and
// write-back model, directed and random stimulus, watchdog
module tb_stk_lk;

  import stk_pkg::*;

  localparam int ENGS_N = 4;
  localparam int DAT_W = 128;
  // Directed commands stay under 40
  localparam int N_RAND = 200;
  localparam int N_CMDS = 40 + N_RAND;
  localparam int LIMIT_NS = (N_CMDS * 3 + 5 + 50) * 4;

  logic clk;
  logic i_reset;
  logic i_lk_vld;
  engid_t i_lk_engid;
  opcode_t i_lk_opcode;
  logic i_lk_isfull;
  logic [DAT_W-1:0] i_lk_dat;
  ptr_t i_lk_ptr;
  logic i_wrbk_vld;
  engid_t i_wrbk_engid;
  logic i_wrbk_head_vld;
  ptr_t i_wrbk_head_ptr;
  logic i_wrbk_tail_vld;
  ptr_t i_wrbk_tail_ptr;
  bank_sel_t o_prev_ce, o_prev_oe, o_dat_ce, o_dat_oe, o_uc_bank_sel;
  line_id_t o_prev_addr, o_dat_addr;
  ptr_t o_prev_din, o_uc_head_ptr, o_uc_tail_ptr;
  logic [DAT_W-1:0] o_dat_din;
  logic o_uc_vld, o_uc_head_vld, o_uc_head_upt, o_uc_tail_vld;
  engid_t o_uc_engid;
  opcode_t o_uc_opcode;
  status_t o_uc_status;

  // PREV SRAM contents, indexed by pointer
  ptr_t prev_mem [256];
  // Write-back's own view of each head
  ptr_t wb_head [ENGS_N];
  ptr_t free_q [$];
  ptr_t rd_addr;
  integer seed = 32'h42e3;
  int tb_err = 0;
  int base_err;
  status_t st;

  stk_lk_top #(.ENGS_N(ENGS_N), .DAT_W(DAT_W)) u_dut (.*);

  stk_lk_checker #(.ENGS_N(ENGS_N), .DAT_W(DAT_W)) u_chk (
    .clk(clk), .i_reset(i_reset), .i_lk_vld(i_lk_vld), .i_lk_engid(i_lk_engid)
  , .i_lk_opcode(i_lk_opcode), .i_lk_isfull(i_lk_isfull), .i_lk_ptr(i_lk_ptr)
  , .i_lk_dat(i_lk_dat), .i_dat_din(o_dat_din), .i_uc_vld(o_uc_vld)
  , .i_act({o_prev_ce, o_prev_oe, o_prev_addr, o_prev_din, o_dat_ce, o_dat_oe,
            o_dat_addr, o_uc_bank_sel, o_uc_status, o_uc_head_vld, o_uc_head_upt,
            o_uc_head_ptr, o_uc_tail_vld, o_uc_tail_ptr, o_uc_engid, o_uc_opcode})
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // One-hot select back to bank number
  function automatic bank_id_t bank_of(input bank_sel_t sel);
    bank_id_t b;
    b = '0;
    for (int i = 0; i < BANKS_N; i++) if (sel[i]) b = bank_id_t'(i);
    return b;
  endfunction

  assign rd_addr = {bank_of(o_prev_ce), o_prev_addr};

  // PREV SRAM and write-back stage
  always @(posedge clk) begin
    i_wrbk_vld <= 1'b0;
    i_wrbk_head_vld <= 1'b0;
    i_wrbk_tail_vld <= 1'b0;
    if (i_reset) begin
      for (int i = 0; i < ENGS_N; i++) wb_head[i] <= '0;
    end else begin
      if (o_prev_ce != '0 && o_prev_oe == '0) prev_mem[rd_addr] <= o_prev_din;
      if (o_uc_vld && o_uc_status == STATUS_OKAY) begin
        i_wrbk_vld <= 1'b1;
        i_wrbk_engid <= o_uc_engid;
        i_wrbk_head_vld <= 1'b1;
        if (o_uc_opcode == OPCODE_PUSH) begin
          i_wrbk_head_ptr <= o_uc_head_ptr;
          i_wrbk_tail_vld <= o_uc_tail_vld;
          i_wrbk_tail_ptr <= o_uc_tail_ptr;
          // Link new entry to the old head
          if (!o_uc_tail_vld) prev_mem[o_uc_head_ptr] <= wb_head[o_uc_engid];
          wb_head[o_uc_engid] <= o_uc_head_ptr;
          void'(free_q.pop_front());
        end else begin
          i_wrbk_head_ptr <= prev_mem[rd_addr];
          free_q.push_back(wb_head[o_uc_engid]);
          wb_head[o_uc_engid] <= prev_mem[rd_addr];
        end
      end
    end
  end

  // One command, then two idle cycles for write-back to land
  task automatic issue(input engid_t eng, input opcode_t op, output status_t got);
    @(posedge clk);
    i_lk_vld <= 1'b1;
    i_lk_engid <= eng;
    i_lk_opcode <= op;
    i_lk_isfull <= (free_q.size() == 0);
    i_lk_ptr <= (free_q.size() != 0) ? free_q[0] : '0;
    i_lk_dat <= {$random(seed), $random(seed), $random(seed), $random(seed)};
    @(negedge clk);
    got = o_uc_status;
    @(posedge clk);
    i_lk_vld <= 1'b0;
    @(posedge clk);
  endtask

  task automatic check_status(input status_t got, input status_t exp, input string what);
    if (got !== exp) begin
      tb_err++;
      $display("[ERROR] %0t ns: %s status %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input int num, input string name);
    int n;
    n = u_chk.err_cnt + tb_err - base_err;
    if (n == 0) $display("test %0d %s: ok", num, name);
    else $display("test %0d %s: %0d errors", num, name, n);
    base_err = u_chk.err_cnt + tb_err;
  endtask

  // Watchdog sized from the command count
  initial begin
    #(LIMIT_NS);
    $display("Timeout: run did not finish within %0d ns", LIMIT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int n;
    // Pool of 16 pointers spread over all banks, line 0 unused
    for (int i = 0; i < 16; i++) free_q.push_back({2'(i % 4), 6'(i / 4 * 5 + 1)});
    for (int a = 0; a < 256; a++) prev_mem[a] = ptr_t'(a) ^ 8'h5a;
    i_reset = 1'b1;
    i_lk_vld = 1'b0;
    i_lk_engid = '0;
    i_lk_opcode = OPCODE_PUSH;
    i_lk_isfull = 1'b0;
    i_lk_dat = '0;
    i_lk_ptr = '0;
    i_wrbk_vld = 1'b0;
    i_wrbk_engid = '0;
    i_wrbk_head_vld = 1'b0;
    i_wrbk_head_ptr = '0;
    i_wrbk_tail_vld = 1'b0;
    i_wrbk_tail_ptr = '0;
    base_err = 0;
    repeat (5) @(posedge clk);
    i_reset <= 1'b0;

    for (int i = 0; i < ENGS_N; i++) begin
      issue(engid_t'(i), OPCODE_POP, st);
      check_status(st, STATUS_ERREMPTY, "pop after reset");
      issue(engid_t'(i), OPCODE_INV, st);
      check_status(st, STATUS_ERREMPTY, "inv after reset");
    end
    end_test(1, "empty after reset");

    issue(engid_t'(0), OPCODE_PUSH, st);
    check_status(st, STATUS_OKAY, "push to empty");
    end_test(2, "push to empty");

    issue(engid_t'(0), OPCODE_PUSH, st);
    issue(engid_t'(0), OPCODE_PUSH, st);
    issue(engid_t'(0), OPCODE_POP, st);
    check_status(st, STATUS_OKAY, "pop after pushes");
    end_test(3, "pop reads head");

    // Drain engine 0 until it reports empty
    n = 0;
    st = STATUS_OKAY;
    while (st != STATUS_ERREMPTY && n < 8) begin
      issue(engid_t'(0), OPCODE_POP, st);
      n++;
    end
    check_status(st, STATUS_ERREMPTY, "pop past last entry");
    end_test(4, "drain to empty");

    n = 0;
    while (free_q.size() != 0 && n < 20) begin
      issue(engid_t'(3), OPCODE_PUSH, st);
      n++;
    end
    issue(engid_t'(3), OPCODE_PUSH, st);
    check_status(st, STATUS_ERRFULL, "push with pool full");
    end_test(5, "pool full");

    for (int k = 0; k < N_RAND; k++) begin
      issue(engid_t'($random(seed) & 3), opcode_t'(($random(seed) & 32'hffff) % 3), st);
    end
    end_test(6, "random mix");

    $display("commands %0d, errors %0d", u_chk.cmd_cnt, u_chk.err_cnt + tb_err);
    if (u_chk.err_cnt + tb_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_stk_lk
